// File: build.f
common/riscv_pkg.sv
common/core_pkg.sv
core/imem.sv
core/reg_file.sv
core/decode_stage.sv
core/execute_stage.sv
rtl/riscv_core.sv
tests/core_checker.sv
tests/core_monitor.sv
tests/tb_riscv_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_riscv_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Errors found

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/tb_riscv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_riscv_core
    import riscv_pkg::*;
    import core_pkg::*;
();
    localparam int PROG_LEN = 64;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 2 + 40;
    localparam logic [31:0] SELF_LOOP = {25'd0, OP_JAL};  // JAL x0,0

    logic        clk;
    logic        rst;
    imem_load_t  load;
    retire_t     retire;
    logic        done;
    int          error_count;
    int          retire_count;
    int          cycles;
    int          failures;
    logic        timed_out;
    integer      seed;
    logic [4:0]  prev_rd;
    logic [31:0] prog [PROG_LEN];

    riscv_core riscv_core_inst (
        .clk(clk),
        .rst(rst),
        .load(load),
        .retire(retire)
    );

    core_monitor core_monitor_inst (
        .clk(clk),
        .rst(rst),
        .load(load),
        .retire(retire),
        .done(done),
        .error_count(error_count),
        .retire_count(retire_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Half of the sources reuse the last destination to exercise the bypasses
    function automatic logic [4:0] pick_src();
        if ($random(seed) % 2 == 0) begin
            return prev_rd;
        end
        return {2'b00, 3'($random(seed))};
    endfunction

    task automatic build_program();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [20:0] off;
        prev_rd = 5'd1;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            kind = int'($unsigned($random(seed)) % 10);
            if (kind >= 8 && i > PROG_LEN - 4) begin
                kind = 0;                              // No room left for a forward skip
            end
            rd = {2'b00, 3'($random(seed))};
            rs1 = pick_src();
            rs2 = pick_src();
            f3 = 3'($random(seed));
            imm = 12'($random(seed));
            off = ($random(seed) % 2 == 0) ? 21'd8 : 21'd12;
            case (kind)
                0, 1, 2, 3: begin
                    imm[11:5] = (f3 == F3_ADD || f3 == F3_SRL) ? {1'b0, imm[10], 5'd0} : 7'd0;
                    prog[i] = {imm[11:5], rs2, rs1, f3, rd, OP_REG};
                end
                4, 5, 6: begin
                    if (f3 == F3_SLL || f3 == F3_SRL) begin
                        imm[11:5] = {1'b0, imm[10] & (f3 == F3_SRL), 5'd0};  // Legal shamt
                    end
                    prog[i] = {imm, rs1, f3, rd, OP_IMM};
                end
                7: prog[i] = {20'($random(seed)), rd, OP_LUI};
                8: prog[i] = {off[12], off[10:5], rs2, rs1, f3[1], 1'b0, f3[0],  // BEQ to BGE
                              off[4:1], off[11], OP_BRANCH};
                default: prog[i] = {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
            endcase
            if (kind != 8) begin
                prev_rd = rd;
            end
        end
        prog[PROG_LEN-1] = SELF_LOOP;
    endtask

    // One word per falling edge, then release reset
    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            @(negedge clk);
            load.valid = 1'b1;
            load.addr = IMEM_AW'(i);
            load.data = prog[i];
        end
        @(negedge clk);
        load = '0;
        rst = 1'b0;
    endtask

    initial begin
        seed = 32'h2768;
        rst = 1'b1;
        load = '0;
        cycles = 0;
        timed_out = 1'b0;
        build_program();
        load_program();
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout: the program did not reach its final loop in %0d cycles", cycles);
            timed_out = 1'b1;
        end
        failures = error_count + (timed_out ? 1 : 0);
        $display("Run finished: %0d errors, %0d retires checked, %0d cycles", failures,
                 retire_count, cycles);
        if (failures != 0) begin
            $display("Errors found");
        end else begin
            $display("No errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/core_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module core_monitor
    import riscv_pkg::*;
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  imem_load_t load,
    input  retire_t    retire,
    output logic       done,
    output int         error_count,
    output int         retire_count
);
    localparam logic [31:0] SELF_LOOP = {25'd0, OP_JAL};  // JAL x0,0

    logic [31:0] prog [IMEM_DEPTH];                    // Copy snooped from the load port
    logic [31:0] regs [32];
    logic [31:0] model_pc;

    function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic [31:0] shift_right(input logic [31:0] a, input logic [4:0] sh,
                                                input logic arith);
        logic [31:0] fill;
        fill = (arith && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0;
        return (a >> sh) | fill;
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return {31'd0, signed_less(a, b)};
            F3_SLTU: return {31'd0, a < b};
            F3_XOR:  return a ^ b;
            F3_SRL:  return shift_right(a, b[4:0], alt);
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return signed_less(a, b);
            F3_BGE:  return !signed_less(a, b);
            default: return 1'b0;
        endcase
    endfunction

    // Steps the ISA model by one instruction and compares with the retire beat
    task automatic check_retire();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp_data;
        logic [31:0] next_pc;
        logic [4:0]  exp_rd;
        logic [2:0]  f3;
        w = prog[model_pc[IMEM_AW+1:2]];
        f3 = w[14:12];
        a = regs[w[19:15]];
        b = regs[w[24:20]];
        exp_rd = w[11:7];
        exp_data = 32'd0;
        next_pc = model_pc + 32'd4;
        case (w[6:0])
            OP_REG: exp_data = alu_model(f3, w[30] && (f3 == F3_ADD || f3 == F3_SRL), a, b);
            OP_IMM: exp_data = alu_model(f3, w[30] && f3 == F3_SRL, a,
                                         {{20{w[31]}}, w[31:20]});
            OP_LUI: exp_data = {w[31:12], 12'h000};
            OP_JAL: begin
                exp_data = model_pc + 32'd4;           // Link address
                next_pc = model_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            OP_BRANCH: begin
                exp_rd = 5'd0;
                if (branch_taken(f3, a, b)) begin
                    next_pc = model_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            default: begin
                $display("Model reached an unsupported instruction %h at pc %h", w, model_pc);
                error_count++;
            end
        endcase
        if (retire.pc !== model_pc) begin
            $display("error at %0t: retire.pc = %h, expected %h", $time, retire.pc, model_pc);
            error_count++;
        end
        if (retire.rd !== exp_rd) begin
            $display("error at %0t: retire.rd = %0d, expected %0d", $time, retire.rd, exp_rd);
            error_count++;
        end
        if (retire.data !== exp_data) begin
            $display("error at %0t: retire.data = %h, expected %h", $time, retire.data,
                     exp_data);
            error_count++;
        end
        if (exp_rd != 5'd0) begin
            regs[exp_rd] = exp_data;                   // x0 stays zero
        end
        model_pc = next_pc;
        retire_count++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            done = 1'b0;
            error_count = 0;
            retire_count = 0;
            model_pc = RESET_PC;
            for (int i = 0; i < 32; i++) begin
                regs[i] = 32'd0;
            end
            if (load.valid) begin
                prog[load.addr] = load.data;
            end
        end else if (retire.valid && !done) begin
            check_retire();
            if (prog[retire.pc[IMEM_AW+1:2]] == SELF_LOOP) begin
                done = 1'b1;                           // Program has reached its end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/core_checker.sv
`timescale 1ns/10ps
`default_nettype none

module core_checker
    import core_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input imem_load_t load,
    input retire_t    retire
);
    // Nothing retires while held and in the first cycle after release
    retire_low_in_reset: assert property (@(posedge clk) rst |=> !retire.valid)
        else $error("retire.valid went high right after a reset cycle");

    retire_low_after_release: assert property (@(posedge clk) $fell(rst) |=> !retire.valid)
        else $error("retire.valid went high in the cycle after reset release");

    load_only_in_reset: assert property (@(posedge clk) !rst |-> !load.valid)
        else $error("load.valid was high while the core was running");

    retire_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        retire.pc[1:0] == 2'b00)
        else $error("retire.pc is not word aligned");

endmodule

bind riscv_core core_checker core_checker_inst (
    .clk(clk),
    .rst(rst),
    .load(load),
    .retire(retire)
);

`default_nettype wire

// File: rtl/riscv_core.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_core
    import riscv_pkg::*;
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  imem_load_t load,
    output retire_t    retire
);
    logic [31:0] pc;
    logic [31:0] instr;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] rd1;
    logic [31:0] rd2;
    ex_stage_t   ex;
    wb_stage_t   wb;
    logic        redirect;
    logic [31:0] target;

    imem imem_inst (
        .clk(clk),
        .rst(rst),
        .load(load),                                   // Program load during reset
        .addr(pc[IMEM_AW+1:2]),                        // From decode_stage
        .instr(instr)                                  // To decode_stage
    );

    reg_file reg_file_inst (
        .clk(clk),
        .rst(rst),
        .rs1(rs1),                                     // From decode_stage
        .rs2(rs2),
        .rd1(rd1),                                     // To decode_stage
        .rd2(rd2),
        .wb(wb)                                        // Write port from writeback
    );

    decode_stage decode_stage_inst (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .pc(pc),
        .rs1(rs1),
        .rs2(rs2),
        .rd1(rd1),
        .rd2(rd2),
        .wb(wb),                                       // Decode bypass
        .redirect(redirect),                           // From execute_stage
        .target(target),
        .ex(ex)                                        // To execute_stage
    );

    execute_stage execute_stage_inst (
        .clk(clk),
        .rst(rst),
        .ex(ex),
        .wb(wb),
        .redirect(redirect),
        .target(target)
    );

    // Retire port mirrors the writeback register
    assign retire = '{valid: wb.valid, pc: wb.pc, rd: wb.rd, data: wb.result};

endmodule

`default_nettype wire

// File: core/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage
    import riscv_pkg::*;
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ex_stage_t   ex,
    output wb_stage_t   wb,
    output logic        redirect,
    output logic [31:0] target
);
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        alt;
    logic [31:0] op_a;
    logic [31:0] rs2_val;
    logic [31:0] op_b;
    logic [31:0] sra_out;
    logic [31:0] alu_out;
    logic        taken;
    wb_stage_t   wb_next;

    assign opcode = ex.instr[6:0];
    assign funct3 = ex.instr[FUNCT3_LSB +: 3];
    assign alt = ex.instr[ALT_BIT];

    // Bypass from the instruction one ahead
    assign op_a = fwd_value(wb, ex.instr[RS1_LSB +: 5], ex.rs1_val);
    assign rs2_val = fwd_value(wb, ex.instr[RS2_LSB +: 5], ex.rs2_val);
    assign op_b = (opcode == OP_REG) ? rs2_val : ex.imm;
    assign sra_out = $signed(op_a) >>> op_b[4:0];

    always_comb begin
        alu_out = 32'd0;
        case (funct3)
            F3_ADD:  alu_out = (opcode == OP_REG && alt) ? op_a - op_b : op_a + op_b;
            F3_SLL:  alu_out = op_a << op_b[4:0];
            F3_SLT:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            F3_SLTU: alu_out = {31'd0, op_a < op_b};
            F3_XOR:  alu_out = op_a ^ op_b;
            F3_SRL:  alu_out = alt ? sra_out : op_a >> op_b[4:0];  // SRAI also sets bit 30
            F3_OR:   alu_out = op_a | op_b;
            F3_AND:  alu_out = op_a & op_b;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = op_a == rs2_val;
            F3_BNE:  taken = op_a != rs2_val;
            F3_BLT:  taken = $signed(op_a) < $signed(rs2_val);
            F3_BGE:  taken = $signed(op_a) >= $signed(rs2_val);
            default: taken = 1'b0;                     // Unsigned branches not supported
        endcase
    end

    assign redirect = ex.valid && (opcode == OP_JAL || (opcode == OP_BRANCH && taken));
    assign target = ex.pc + ex.imm;

    always_comb begin
        wb_next.valid = ex.valid;
        wb_next.pc = ex.pc;
        wb_next.rd = ex.instr[RD_LSB +: 5];
        wb_next.reg_write = 1'b1;
        case (opcode)
            OP_REG, OP_IMM: wb_next.result = alu_out;
            OP_LUI:         wb_next.result = ex.imm;
            OP_JAL:         wb_next.result = ex.pc + 32'd4;  // Link address
            default: begin                             // Branches retire rd 0, data 0
                wb_next.rd = 5'd0;
                wb_next.reg_write = 1'b0;
                wb_next.result = 32'd0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        wb <= wb_next;
        if (rst) begin
            wb.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: core/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage
    import riscv_pkg::*;
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    input  logic [31:0] rd1,
    input  logic [31:0] rd2,
    input  wb_stage_t   wb,
    input  logic        redirect,
    input  logic [31:0] target,
    output ex_stage_t   ex
);
    logic [6:0]  opcode;
    logic [31:0] imm;
    ex_stage_t   ex_next;

    assign opcode = instr[6:0];
    assign rs1 = instr[RS1_LSB +: 5];
    assign rs2 = instr[RS2_LSB +: 5];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= redirect ? target : pc + 32'd4;    // Taken branch or JAL from execute
        end
    end

    always_comb begin
        case (opcode)
            OP_LUI:    imm = {instr[31:12], 12'd0};
            OP_BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            OP_JAL:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:   imm = {{21{instr[31]}}, instr[30:20]};  // I-type
        endcase
    end

    // Writeback result is not yet in the register file this cycle
    assign ex_next = '{
        valid:   1'b1,
        pc:      pc,
        instr:   instr,
        rs1_val: fwd_value(wb, rs1, rd1),
        rs2_val: fwd_value(wb, rs2, rd2),
        imm:     imm
    };

    always_ff @(posedge clk) begin
        ex <= ex_next;
        if (rst || redirect) begin
            ex.valid <= 1'b0;                          // Squash the wrong-path fetch
        end
    end

endmodule

`default_nettype wire

// File: core/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    input  wb_stage_t   wb
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wb.valid && wb.reg_write && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];  // x0 reads as zero
    assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

// File: core/imem.sv
`timescale 1ns/10ps
`default_nettype none

module imem
    import riscv_pkg::*;
    import core_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  imem_load_t         load,
    input  logic [IMEM_AW-1:0] addr,
    output logic [31:0]        instr
);
    logic [31:0] mem [IMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (rst && load.valid) begin                   // Loading only while the core is held
            mem[load.addr] <= load.data;
        end
    end

    // Fetch is combinational so decode sees the word in the same cycle
    assign instr = mem[addr];

endmodule

`default_nettype wire

// File: common/core_pkg.sv
`default_nettype none

package core_pkg;

    import riscv_pkg::*;

    typedef struct packed {
        logic               valid;
        logic [IMEM_AW-1:0] addr;                      // Word address
        logic [31:0]        data;
    } imem_load_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
    } ex_stage_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        reg_write;
        logic [31:0] result;
    } wb_stage_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
    } retire_t;

    // Writeback bypass shared by the decode and execute stages
    function automatic logic [31:0] fwd_value(input wb_stage_t wb_in, input logic [4:0] rs,
                                              input logic [31:0] reg_val);
        if (wb_in.valid && wb_in.reg_write && wb_in.rd != 5'd0 && wb_in.rd == rs) begin
            return wb_in.result;
        end
        return reg_val;
    endfunction

endpackage

`default_nettype wire

// File: common/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam int IMEM_DEPTH = 256;                   // Words
    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;

    // ALU funct3
    localparam logic [2:0] F3_ADD = 3'b000;            // ADD and SUB
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;            // SRL and SRA
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // Instruction field positions
    localparam int RD_LSB = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int ALT_BIT = 30;                       // Selects SUB and SRA

endpackage

`default_nettype wire
